//--- Bender.yml
package:
  name: dbg_mem

sources:
  - src/dbg_mem_pkg.sv
  - src/uart_byte_rx.sv
  - src/uart_byte_tx.sv
  - src/uart_dbg_engine.sv
  - src/axil_mem_port.sv
  - src/mem_arbiter.sv
  - src/scratch_mem.sv
  - src/dbg_mem_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_checker.sv
      - dv/dbg_mem_assert.sv
      - dv/tb_dbg_mem.sv

//--- dv/dbg_mem_assert.sv
////////////////////////////////////////////////////////////
// Grant and read-tag properties, bound into the arbiter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dbg_mem_assert import dbg_mem_pkg::*; (
  input logic     clk,
  input logic     rst_n_i,
  input mem_req_t dbg_req_i,
  input logic     dbg_valid_i,
  input logic     dbg_gnt_o,
  input logic     dbg_rvalid_o,
  input mem_req_t bus_req_i,
  input logic     bus_valid_i,
  input logic     bus_gnt_o,
  input logic     bus_rvalid_o
);

  int fail_cnt = 0;

  one_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(dbg_gnt_o && bus_gnt_o))
    else begin
      $error("both masters granted");
      fail_cnt++;
    end

  dbg_gnt_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    dbg_gnt_o |-> dbg_valid_i)
    else begin
      $error("UART engine granted without request");
      fail_cnt++;
    end

  bus_gnt_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    bus_gnt_o |-> bus_valid_i)
    else begin
      $error("AXI port granted without request");
      fail_cnt++;
    end

  // Read data tag one cycle after a read grant
  dbg_rd_tag: assert property (@(posedge clk) disable iff (!rst_n_i)
    (dbg_gnt_o && !dbg_req_i.we) |=> dbg_rvalid_o)
    else begin
      $error("UART read tag missing");
      fail_cnt++;
    end

  bus_rd_tag: assert property (@(posedge clk) disable iff (!rst_n_i)
    (bus_gnt_o && !bus_req_i.we) |=> bus_rvalid_o)
    else begin
      $error("AXI read tag missing");
      fail_cnt++;
    end

endmodule

bind mem_arbiter dbg_mem_assert u_assert (.*);

//--- dv/tb_checker.sv
////////////////////////////////////////////////////////////
// Reference memory model, decodes UART TX frames and checks
// AXI4-Lite responses against the model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_checker import dbg_mem_pkg::*; (
  input logic      clk,
  input logic      rst_n_i,
  input logic      uart_tx_i,
  input axil_req_t axil_req_i,
  input axil_rsp_t axil_rsp_i
);

  logic [7:0]        ref_mem [MEM_WORDS*4];
  logic [7:0]        exp_tx [$];
  logic [DATA_W-1:0] rd_exp [$];
  logic              rd_err [$];
  logic              wr_err [$];
  int                err_cnt = 0;
  int                chk_cnt = 0;
  logic              r_hold = 1'b0;
  logic              b_hold = 1'b0;
  logic [DATA_W-1:0] r_prev;
  logic [1:0]        b_prev;

  task automatic report_fail(input string msg);
    $display("Fail: %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  // Reference read, little-endian bytes at a wrapped address
  function automatic logic [DATA_W-1:0] ref_read_word(input logic [AXIL_ADDR_W-1:0] addr);
    logic [MEM_ADDR_W-1:0] a;
    a = {addr[MEM_ADDR_W-1:2], 2'b00};
    return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
  endfunction

  function automatic logic [7:0] ref_read_byte(input logic [AXIL_ADDR_W-1:0] addr);
    return ref_mem[addr[MEM_ADDR_W-1:0]];
  endfunction

  task automatic ref_write_byte(input logic [AXIL_ADDR_W-1:0] addr, input logic [7:0] data);
    ref_mem[addr[MEM_ADDR_W-1:0]] = data;
  endtask

  task automatic expect_tx(input logic [7:0] b);
    exp_tx.push_back(b);
  endtask

  task automatic check_idle();
    chk_cnt++;
    if (uart_tx_i !== 1'b1) report_fail("uart_tx_o not idle high after reset");
    if ({axil_rsp_i.aw_ready, axil_rsp_i.w_ready, axil_rsp_i.ar_ready,
         axil_rsp_i.b_valid, axil_rsp_i.r_valid} !== 5'b0)
      report_fail("AXI ready or valid high after reset");
  endtask

  ////////////////////////////////////////////////////////////
  // UART frame decoder, samples mid-bit
  ////////////////////////////////////////////////////////////

  always begin
    logic [7:0] b;
    @(posedge clk);
    if (rst_n_i && uart_tx_i == 1'b0) begin
      repeat (CLKS_PER_BIT / 2) @(posedge clk);
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(posedge clk);
        b[i] = uart_tx_i;
      end
      repeat (CLKS_PER_BIT) @(posedge clk);
      if (uart_tx_i !== 1'b1) report_fail("UART stop bit low");
      chk_cnt++;
      if (exp_tx.size() == 0) begin
        report_fail($sformatf("unexpected UART byte 0x%02h", b));
      end else if (exp_tx[0] !== b) begin
        report_fail($sformatf("UART byte 0x%02h, expected 0x%02h", b, exp_tx[0]));
        void'(exp_tx.pop_front());
      end else begin
        void'(exp_tx.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // AXI monitor, evaluated at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    logic err;
    logic [DATA_W-1:0] exp_d;
    if (rst_n_i) begin
      // AW and W are taken in the same cycle
      if (axil_rsp_i.w_ready !== axil_rsp_i.aw_ready)
        report_fail("w_ready and aw_ready differ");
      if (axil_req_i.ar_valid && axil_rsp_i.ar_ready) begin
        rd_err.push_back(axil_req_i.ar_addr >= AXIL_ADDR_W'(MEM_WORDS * 4));
        rd_exp.push_back(ref_read_word(axil_req_i.ar_addr));
      end
      if (axil_req_i.aw_valid && axil_rsp_i.aw_ready) begin
        err = (axil_req_i.aw_addr >= AXIL_ADDR_W'(MEM_WORDS * 4));
        wr_err.push_back(err);
        if (!err) begin
          for (int b = 0; b < STRB_W; b++) begin
            if (axil_req_i.w_strb[b])
              ref_write_byte({axil_req_i.aw_addr[AXIL_ADDR_W-1:2], 2'(b)},
                             axil_req_i.w_data[8*b +: 8]);
          end
        end
      end
      if (axil_rsp_i.r_valid) begin
        if (r_hold && axil_rsp_i.r_data !== r_prev)
          report_fail("r_data changed while r_ready was low");
        if (axil_req_i.r_ready) begin
          chk_cnt++;
          if (rd_exp.size() == 0) begin
            report_fail("read response without a read request");
          end else begin
            err   = rd_err.pop_front();
            exp_d = rd_exp.pop_front();
            if (axil_rsp_i.r_resp !== (err ? RESP_SLVERR : RESP_OKAY))
              report_fail($sformatf("r_resp %0d, expected %0d", axil_rsp_i.r_resp,
                                    err ? RESP_SLVERR : RESP_OKAY));
            else if (!err && axil_rsp_i.r_data !== exp_d)
              report_fail($sformatf("r_data 0x%08h, expected 0x%08h",
                                    axil_rsp_i.r_data, exp_d));
          end
        end
        r_hold = !axil_req_i.r_ready;
        r_prev = axil_rsp_i.r_data;
      end else begin
        r_hold = 1'b0;
      end
      if (axil_rsp_i.b_valid) begin
        if (b_hold && axil_rsp_i.b_resp !== b_prev)
          report_fail("b_resp changed while b_ready was low");
        if (axil_req_i.b_ready) begin
          chk_cnt++;
          if (wr_err.size() == 0) begin
            report_fail("write response without a write request");
          end else begin
            err = wr_err.pop_front();
            if (axil_rsp_i.b_resp !== (err ? RESP_SLVERR : RESP_OKAY))
              report_fail($sformatf("b_resp %0d, expected %0d", axil_rsp_i.b_resp,
                                    err ? RESP_SLVERR : RESP_OKAY));
          end
        end
        b_hold = !axil_req_i.b_ready;
        b_prev = axil_rsp_i.b_resp;
      end else begin
        b_hold = 1'b0;
      end
    end
  end

endmodule

//--- dv/tb_clk_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock (100 ns) and reset held for 10 cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- dv/tb_dbg_mem.sv
////////////////////////////////////////////////////////////
// Testbench top, drives UART and AXI4-Lite stimulus into the
// debug memory subsystem and prints the final report
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dbg_mem import dbg_mem_pkg::*; ();

  localparam int FRAME_CYC   = 10 * CLKS_PER_BIT;
  localparam int UART_FRAMES = 100;
  localparam int AXI_TXNS    = 640;
  localparam int AXI_WORST   = 24;
  localparam int WDOG_CYC    = 2 * (UART_FRAMES * FRAME_CYC + AXI_TXNS * AXI_WORST);
  localparam int DRAIN_CYC   = 40 * FRAME_CYC;

  logic        clk, rst_n;
  logic        uart_rx, uart_tx;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic [15:0] lfsr_q = 16'd87;
  logic        stall_en = 1'b0;
  logic        uart_wr_done = 1'b0;
  int          tb_err = 0;
  logic [7:0]  wr_bytes [16];

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  dbg_mem_top uut (
    .clk        ( clk      ),
    .rst_n_i    ( rst_n    ),
    .uart_rx_i  ( uart_rx  ),
    .uart_tx_o  ( uart_tx  ),
    .axil_req_i ( axil_req ),
    .axil_rsp_o ( axil_rsp )
  );

  tb_checker u_checker (
    .clk        ( clk      ),
    .rst_n_i    ( rst_n    ),
    .uart_tx_i  ( uart_tx  ),
    .axil_req_i ( axil_req ),
    .axil_rsp_i ( axil_rsp )
  );

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] next_rand(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // Checker, bound assertions and testbench errors together
  function automatic int total_errors();
    return u_checker.err_cnt + uut.i_arbiter.u_assert.fail_cnt + tb_err;
  endfunction

  task automatic send_uart_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk) uart_rx <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic send_uart_cmd(input logic [7:0] cmd, input logic [15:0] addr,
                               input logic [15:0] len);
    send_uart_byte(cmd);
    send_uart_byte(addr[7:0]);
    send_uart_byte(addr[15:8]);
    send_uart_byte(len[7:0]);
    send_uart_byte(len[15:8]);
  endtask

  task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    @(posedge clk);
    axil_req.aw_valid <= 1'b1;
    axil_req.aw_addr  <= addr;
    axil_req.w_valid  <= 1'b1;
    axil_req.w_data   <= data;
    axil_req.w_strb   <= strb;
    do @(negedge clk); while (!axil_rsp.aw_ready);
    @(posedge clk);
    axil_req.aw_valid <= 1'b0;
    axil_req.w_valid  <= 1'b0;
    axil_req.b_ready  <= stall_en ? next_rand(1) : 1'b1;
    forever begin
      @(negedge clk);
      if (axil_rsp.b_valid && axil_req.b_ready) break;
      @(posedge clk) axil_req.b_ready <= stall_en ? next_rand(1) : 1'b1;
    end
    @(posedge clk) axil_req.b_ready <= 1'b0;
  endtask

  task automatic axi_read(input logic [15:0] addr);
    @(posedge clk);
    axil_req.ar_valid <= 1'b1;
    axil_req.ar_addr  <= addr;
    do @(negedge clk); while (!axil_rsp.ar_ready);
    @(posedge clk);
    axil_req.ar_valid <= 1'b0;
    axil_req.r_ready  <= stall_en ? next_rand(1) : 1'b1;
    forever begin
      @(negedge clk);
      if (axil_rsp.r_valid && axil_req.r_ready) break;
      @(posedge clk) axil_req.r_ready <= stall_en ? next_rand(1) : 1'b1;
    end
    @(posedge clk) axil_req.r_ready <= 1'b0;
  endtask

  // Wait until every expected UART byte has come back
  task automatic wait_tx_done();
    int n;
    n = 0;
    while (u_checker.exp_tx.size() != 0 && n < DRAIN_CYC) begin
      @(posedge clk);
      n++;
    end
    if (u_checker.exp_tx.size() != 0) begin
      $display("UART response missing: %0d bytes never arrived", u_checker.exp_tx.size());
      tb_err++;
    end
  endtask

  initial begin
    uart_rx  = 1'b1;
    axil_req = '0;
    @(posedge rst_n);
    repeat (2) @(posedge clk);
    u_checker.check_idle();

    // Fill the memory, pattern from the full byte address
    for (int w = 0; w < MEM_WORDS; w++)
      axi_write(16'(4 * w), {16'hC0DE ^ 16'(4 * w), 16'(4 * w)}, 4'hF);

    // Echo of a lone ACK, then a quiet line
    u_checker.expect_tx(BYTE_ACK);
    send_uart_byte(BYTE_ACK);
    wait_tx_done();
    repeat (2 * FRAME_CYC) @(posedge clk);

    // UART write at an unaligned address, AXI read back
    u_checker.expect_tx(BYTE_ACK);
    u_checker.expect_tx(BYTE_EOT);
    send_uart_cmd(CMD_WRITE, 16'h0123, 16'd8);
    for (int i = 0; i < 8; i++) begin
      wr_bytes[i] = next_rand(8);
      u_checker.ref_write_byte(16'h0123 + 16'(i), wr_bytes[i]);
      send_uart_byte(wr_bytes[i]);
    end
    wait_tx_done();
    for (int a = 16'h0120; a < 16'h012C; a += 4) axi_read(16'(a));

    // Strobed AXI writes, then a UART read across them
    for (int a = 16'h0200; a < 16'h0210; a += 4) axi_write(16'(a), next_rand(32), next_rand(4));
    u_checker.expect_tx(BYTE_ACK);
    for (int i = 0; i < 12; i++) u_checker.expect_tx(u_checker.ref_read_byte(16'h0202 + 16'(i)));
    u_checker.expect_tx(BYTE_EOT);
    send_uart_cmd(CMD_READ, 16'h0202, 16'd12);
    wait_tx_done();
    u_checker.expect_tx(BYTE_ACK);
    u_checker.expect_tx(BYTE_EOT);
    send_uart_cmd(CMD_WRITE, 16'h0300, 16'd0);
    wait_tx_done();

    // Out of range accesses, word 0 must stay intact
    axi_read(16'(MEM_WORDS * 4));
    axi_write(16'(MEM_WORDS * 4), 32'hDEADBEEF, 4'hF);
    axi_read(16'h0000);

    // UART write wrapping past the top, AXI traffic with stalls
    for (int i = 0; i < 16; i++) wr_bytes[i] = next_rand(8);
    u_checker.expect_tx(BYTE_ACK);
    u_checker.expect_tx(BYTE_EOT);
    stall_en = 1'b1;
    fork
      begin
        send_uart_cmd(CMD_WRITE, 16'h03F8, 16'd16);
        for (int i = 0; i < 16; i++) begin
          u_checker.ref_write_byte(16'h03F8 + 16'(i), wr_bytes[i]);
          send_uart_byte(wr_bytes[i]);
        end
        uart_wr_done = 1'b1;
      end
      begin : axi_traffic
        int n;
        n = 0;
        // Back to back AXI accesses for as long as the UART write runs
        while (!uart_wr_done) begin
          axi_write(16'h0040 + 16'(4 * (n % 8)), next_rand(32), next_rand(4));
          axi_read(16'h0040 + 16'(4 * ((n + 3) % 8)));
          n++;
        end
      end
    join
    wait_tx_done();
    for (int w = 0; w < MEM_WORDS; w++) axi_read(16'(4 * w));
    stall_en = 1'b0;
    repeat (20) @(posedge clk);

    $display("Checks: %0d, errors: %0d", u_checker.chk_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog sized from the frame and transaction budget
  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run did not finish", WDOG_CYC);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- src.f
src/dbg_mem_pkg.sv
src/uart_byte_rx.sv
src/uart_byte_tx.sv
src/uart_dbg_engine.sv
src/axil_mem_port.sv
src/mem_arbiter.sv
src/scratch_mem.sv
src/dbg_mem_top.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/dbg_mem_assert.sv
dv/tb_dbg_mem.sv

//--- src/axil_mem_port.sv
////////////////////////////////////////////////////////////
// AXI4-Lite slave port onto the scratch memory, one
// transaction in flight at a time
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axil_mem_port import dbg_mem_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  axil_req_t         axil_req_i,
  output axil_rsp_t         axil_rsp_o,
  output mem_req_t          mem_req_o,
  output logic              mem_req_valid_o,
  input  logic              mem_gnt_i,
  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i
);

  typedef enum logic [1:0] {P_IDLE, P_REQ, P_RESP} port_state_e;

  port_state_e            state_q;
  logic                   is_rd_q, err_q;
  logic [MEM_ADDR_W-1:0]  addr_q;
  logic [DATA_W-1:0]      wdata_q, rdata_q;
  logic [STRB_W-1:0]      wstrb_q;
  logic                   ar_acc, aw_acc;
  logic [AXIL_ADDR_W-1:0] acc_addr;
  logic                   acc_err, resp_done;

  // Reads win when both address channels are valid together
  assign ar_acc    = (state_q == P_IDLE) && axil_req_i.ar_valid;
  assign aw_acc    = (state_q == P_IDLE) && !axil_req_i.ar_valid
                     && axil_req_i.aw_valid && axil_req_i.w_valid;
  assign acc_addr  = ar_acc ? axil_req_i.ar_addr : axil_req_i.aw_addr;
  assign acc_err   = (acc_addr >= AXIL_ADDR_W'(MEM_WORDS * 4));
  assign resp_done = is_rd_q ? axil_req_i.r_ready : axil_req_i.b_ready;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= P_IDLE;
      is_rd_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        P_IDLE: begin
          if (ar_acc || aw_acc) begin
            is_rd_q <= ar_acc;
            err_q   <= acc_err;
            // Out of range skips the memory entirely
            state_q <= acc_err ? P_RESP : P_REQ;
          end
        end
        P_REQ: begin
          if (mem_gnt_i) state_q <= P_RESP;
        end
        default: begin
          if (resp_done) state_q <= P_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_acc || aw_acc) begin
      addr_q  <= acc_addr[MEM_ADDR_W-1:0];
      wdata_q <= axil_req_i.w_data;
      wstrb_q <= axil_req_i.w_strb;
    end
    if (ar_acc) rdata_q <= '0;
    else if (mem_rvalid_i) rdata_q <= mem_rdata_i;
  end

  assign mem_req_valid_o = (state_q == P_REQ);
  assign mem_req_o.addr  = addr_q[MEM_ADDR_W-1:2];
  assign mem_req_o.we    = !is_rd_q;
  assign mem_req_o.wdata = wdata_q;
  assign mem_req_o.strb  = is_rd_q ? '0 : wstrb_q;

  always_comb begin
    axil_rsp_o.aw_ready = aw_acc;
    axil_rsp_o.w_ready  = aw_acc;
    axil_rsp_o.ar_ready = ar_acc;
    axil_rsp_o.b_valid  = (state_q == P_RESP) && !is_rd_q;
    axil_rsp_o.b_resp   = err_q ? RESP_SLVERR : RESP_OKAY;
    axil_rsp_o.r_valid  = (state_q == P_RESP) && is_rd_q;
    // Read data is live in the first response cycle, held after
    axil_rsp_o.r_data   = mem_rvalid_i ? mem_rdata_i : rdata_q;
    axil_rsp_o.r_resp   = err_q ? RESP_SLVERR : RESP_OKAY;
  end

endmodule

//--- src/dbg_mem_pkg.sv
////////////////////////////////////////////////////////////
// Shared constants and bus structs for the debug memory
// subsystem, imported by every RTL module
////////////////////////////////////////////////////////////

package dbg_mem_pkg;

  // UART timing
  localparam int unsigned CLKS_PER_BIT = 16;
  localparam int unsigned BIT_CNT_W    = $clog2(CLKS_PER_BIT);

  // Memory geometry
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned STRB_W      = DATA_W / 8;
  localparam int unsigned MEM_WORDS   = 256;
  localparam int unsigned MEM_ADDR_W  = 10;
  localparam int unsigned WORD_ADDR_W = MEM_ADDR_W - 2;
  localparam int unsigned AXIL_ADDR_W = 16;

  // Debug protocol fields, little-endian on the wire
  localparam int unsigned FIELD_BYTES = 2;
  localparam int unsigned LEN_W       = FIELD_BYTES * 8;
  localparam int unsigned HDR_W       = 2 * LEN_W;
  localparam int unsigned HDR_CNT_W   = $clog2(2 * FIELD_BYTES);

  localparam logic [7:0] CMD_READ  = 8'h11;
  localparam logic [7:0] CMD_WRITE = 8'h12;
  localparam logic [7:0] BYTE_ACK  = 8'h06;
  localparam logic [7:0] BYTE_EOT  = 8'h04;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  ////////////////////////////////////////////////////////////
  // Bus structs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [WORD_ADDR_W-1:0] addr;
    logic                   we;
    logic [DATA_W-1:0]      wdata;
    logic [STRB_W-1:0]      strb;
  } mem_req_t;

  typedef struct packed {
    logic                   aw_valid;
    logic [AXIL_ADDR_W-1:0] aw_addr;
    logic                   w_valid;
    logic [DATA_W-1:0]      w_data;
    logic [STRB_W-1:0]      w_strb;
    logic                   b_ready;
    logic                   ar_valid;
    logic [AXIL_ADDR_W-1:0] ar_addr;
    logic                   r_ready;
  } axil_req_t;

  typedef struct packed {
    logic              aw_ready;
    logic              w_ready;
    logic              ar_ready;
    logic              b_valid;
    logic [1:0]        b_resp;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
    logic [1:0]        r_resp;
  } axil_rsp_t;

endpackage

//--- src/dbg_mem_top.sv
////////////////////////////////////////////////////////////
// Debug memory subsystem top, UART debug engine and AXI4-Lite
// port sharing one scratch memory
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dbg_mem_top import dbg_mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      uart_rx_i,
  output logic      uart_tx_o,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o
);

  logic              rx_valid, tx_send, tx_busy;
  logic [7:0]        rx_byte, tx_byte;
  mem_req_t          dbg_req, bus_req, mem_req;
  logic              dbg_valid, dbg_gnt, dbg_rvalid;
  logic              bus_valid, bus_gnt, bus_rvalid;
  logic              mem_en;
  logic [DATA_W-1:0] mem_rdata;

  ////////////////////////////////////////////////////////////
  // UART debug path
  ////////////////////////////////////////////////////////////

  uart_byte_rx i_uart_rx (
    .clk          ( clk       ),
    .rst_n_i      ( rst_n_i   ),
    .rx_i         ( uart_rx_i ),
    .byte_valid_o ( rx_valid  ),
    .byte_o       ( rx_byte   )
  );

  uart_byte_tx i_uart_tx (
    .clk     ( clk       ),
    .rst_n_i ( rst_n_i   ),
    .send_i  ( tx_send   ),
    .byte_i  ( tx_byte   ),
    .busy_o  ( tx_busy   ),
    .tx_o    ( uart_tx_o )
  );

  uart_dbg_engine i_dbg_engine (
    .clk             ( clk        ),
    .rst_n_i         ( rst_n_i    ),
    .rx_valid_i      ( rx_valid   ),
    .rx_byte_i       ( rx_byte    ),
    .tx_send_o       ( tx_send    ),
    .tx_byte_o       ( tx_byte    ),
    .tx_busy_i       ( tx_busy    ),
    .mem_req_o       ( dbg_req    ),
    .mem_req_valid_o ( dbg_valid  ),
    .mem_gnt_i       ( dbg_gnt    ),
    .mem_rvalid_i    ( dbg_rvalid ),
    .mem_rdata_i     ( mem_rdata  )
  );

  ////////////////////////////////////////////////////////////
  // AXI4-Lite path and shared memory
  ////////////////////////////////////////////////////////////

  axil_mem_port i_axil_port (
    .clk             ( clk        ),
    .rst_n_i         ( rst_n_i    ),
    .axil_req_i      ( axil_req_i ),
    .axil_rsp_o      ( axil_rsp_o ),
    .mem_req_o       ( bus_req    ),
    .mem_req_valid_o ( bus_valid  ),
    .mem_gnt_i       ( bus_gnt    ),
    .mem_rvalid_i    ( bus_rvalid ),
    .mem_rdata_i     ( mem_rdata  )
  );

  mem_arbiter i_arbiter (
    .clk          ( clk        ),
    .rst_n_i      ( rst_n_i    ),
    .dbg_req_i    ( dbg_req    ),
    .dbg_valid_i  ( dbg_valid  ),
    .dbg_gnt_o    ( dbg_gnt    ),
    .dbg_rvalid_o ( dbg_rvalid ),
    .bus_req_i    ( bus_req    ),
    .bus_valid_i  ( bus_valid  ),
    .bus_gnt_o    ( bus_gnt    ),
    .bus_rvalid_o ( bus_rvalid ),
    .mem_req_o    ( mem_req    ),
    .mem_en_o     ( mem_en     )
  );

  scratch_mem i_mem (
    .clk     ( clk       ),
    .en_i    ( mem_en    ),
    .req_i   ( mem_req   ),
    .rdata_o ( mem_rdata )
  );

endmodule

//--- src/mem_arbiter.sv
////////////////////////////////////////////////////////////
// Round-robin arbiter between the UART engine and the
// AXI4-Lite port in front of the scratch memory
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_arbiter import dbg_mem_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  mem_req_t dbg_req_i,
  input  logic     dbg_valid_i,
  output logic     dbg_gnt_o,
  output logic     dbg_rvalid_o,
  input  mem_req_t bus_req_i,
  input  logic     bus_valid_i,
  output logic     bus_gnt_o,
  output logic     bus_rvalid_o,
  output mem_req_t mem_req_o,
  output logic     mem_en_o
);

  // High when the bus port has priority on a tie
  logic prio_bus_q;

  assign dbg_gnt_o = dbg_valid_i && (!bus_valid_i || !prio_bus_q);
  assign bus_gnt_o = bus_valid_i && (!dbg_valid_i || prio_bus_q);
  assign mem_en_o  = dbg_gnt_o || bus_gnt_o;
  assign mem_req_o = bus_gnt_o ? bus_req_i : dbg_req_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      prio_bus_q   <= 1'b0;
      dbg_rvalid_o <= 1'b0;
      bus_rvalid_o <= 1'b0;
    end else begin
      if (dbg_gnt_o) prio_bus_q <= 1'b1;
      else if (bus_gnt_o) prio_bus_q <= 1'b0;
      // Tag the pending read with its owner
      dbg_rvalid_o <= dbg_gnt_o && !dbg_req_i.we;
      bus_rvalid_o <= bus_gnt_o && !bus_req_i.we;
    end
  end

endmodule

//--- src/scratch_mem.sv
////////////////////////////////////////////////////////////
// Single-ported scratch RAM, byte strobes, registered read
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scratch_mem import dbg_mem_pkg::*; (
  input  logic              clk,
  input  logic              en_i,
  input  mem_req_t          req_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (req_i.we) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (req_i.strb[b]) mem_q[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end else begin
        rdata_o <= mem_q[req_i.addr];
      end
    end
  end

endmodule

//--- src/uart_byte_rx.sv
////////////////////////////////////////////////////////////
// UART 8N1 receiver, emits one byte per good frame
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_byte_rx import dbg_mem_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       rx_i,
  output logic       byte_valid_o,
  output logic [7:0] byte_o
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e            state_q;
  logic                 rx_meta_q, rx_sync_q;
  logic [BIT_CNT_W-1:0] cnt_q;
  logic [2:0]           bit_q;
  logic [7:0]           shift_q;
  logic                 bit_end;

  assign bit_end = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rx_meta_q    <= 1'b1;
      rx_sync_q    <= 1'b1;
      state_q      <= RX_IDLE;
      cnt_q        <= '0;
      bit_q        <= '0;
      byte_valid_o <= 1'b0;
    end else begin
      rx_meta_q    <= rx_i;
      rx_sync_q    <= rx_meta_q;
      byte_valid_o <= 1'b0;
      cnt_q        <= cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_sync_q) state_q <= RX_START;
        end
        // Recheck the line half a bit in, glitches go back to idle
        RX_START: begin
          if (cnt_q == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= RX_STOP;
          end
        end
        default: begin
          if (bit_end) begin
            byte_valid_o <= rx_sync_q;
            state_q      <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_end) shift_q <= {rx_sync_q, shift_q[7:1]};
  end

  assign byte_o = shift_q;

endmodule

//--- src/uart_byte_tx.sv
////////////////////////////////////////////////////////////
// UART 8N1 transmitter, one frame per send request
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_byte_tx import dbg_mem_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       send_i,
  input  logic [7:0] byte_i,
  output logic       busy_o,
  output logic       tx_o
);

  logic                 busy_q;
  logic [BIT_CNT_W-1:0] cnt_q;
  logic [3:0]           bit_q;
  logic [9:0]           frame_q;
  logic                 bit_end;

  assign bit_end = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      bit_q  <= '0;
    end else if (!busy_q) begin
      cnt_q <= '0;
      bit_q <= '0;
      if (send_i) busy_q <= 1'b1;
    end else begin
      cnt_q <= cnt_q + 1'b1;
      if (bit_end) begin
        bit_q <= bit_q + 1'b1;
        // Stop bit done, frame complete
        if (bit_q == 4'd9) busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (send_i && !busy_q) frame_q <= {1'b1, byte_i, 1'b0};
    else if (busy_q && bit_end) frame_q <= {1'b1, frame_q[9:1]};
  end

  assign busy_o = busy_q;
  assign tx_o   = busy_q ? frame_q[0] : 1'b1;

endmodule

//--- src/uart_dbg_engine.sv
////////////////////////////////////////////////////////////
// Debug command engine, turns UART read and write commands
// into byte accesses on the scratch memory
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_dbg_engine import dbg_mem_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              rx_valid_i,
  input  logic [7:0]        rx_byte_i,
  output logic              tx_send_o,
  output logic [7:0]        tx_byte_o,
  input  logic              tx_busy_i,
  output mem_req_t          mem_req_o,
  output logic              mem_req_valid_o,
  input  logic              mem_gnt_i,
  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i
);

  typedef enum logic [3:0] {
    S_IDLE, S_HDR, S_ACK, S_DATA, S_DATA_RX, S_DATA_REQ, S_DATA_RD, S_DATA_TX, S_EOT
  } eng_state_e;

  eng_state_e            state_q;
  logic [HDR_CNT_W-1:0]  hdr_cnt_q;
  logic [HDR_W-1:0]      hdr_q, hdr_next;
  logic [MEM_ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]      len_q;
  logic                  is_write_q;
  logic                  ack_only_q;
  logic [7:0]            data_q;

  // Header bytes shift in from the top, so the first byte ends lowest
  assign hdr_next = {rx_byte_i, hdr_q[HDR_W-1:8]};

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q    <= S_IDLE;
      hdr_cnt_q  <= '0;
      addr_q     <= '0;
      len_q      <= '0;
      is_write_q <= 1'b0;
      ack_only_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (rx_valid_i) begin
            if (rx_byte_i == BYTE_ACK) begin
              ack_only_q <= 1'b1;
              state_q    <= S_ACK;
            end else if (rx_byte_i == CMD_READ || rx_byte_i == CMD_WRITE) begin
              is_write_q <= (rx_byte_i == CMD_WRITE);
              ack_only_q <= 1'b0;
              hdr_cnt_q  <= '0;
              state_q    <= S_HDR;
            end
          end
        end
        S_HDR: begin
          if (rx_valid_i) begin
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_cnt_q == HDR_CNT_W'(2 * FIELD_BYTES - 1)) begin
              addr_q  <= hdr_next[MEM_ADDR_W-1:0];
              len_q   <= hdr_next[HDR_W-1:LEN_W];
              state_q <= S_ACK;
            end
          end
        end
        S_ACK: begin
          if (!tx_busy_i) state_q <= ack_only_q ? S_IDLE : S_DATA;
        end
        S_DATA: begin
          if (len_q == '0) state_q <= S_EOT;
          else state_q <= is_write_q ? S_DATA_RX : S_DATA_REQ;
        end
        S_DATA_RX: begin
          if (rx_valid_i) state_q <= S_DATA_REQ;
        end
        S_DATA_REQ: begin
          if (mem_gnt_i) begin
            if (is_write_q) begin
              addr_q  <= addr_q + 1'b1;
              len_q   <= len_q - 1'b1;
              state_q <= S_DATA;
            end else begin
              state_q <= S_DATA_RD;
            end
          end
        end
        S_DATA_RD: begin
          if (mem_rvalid_i) state_q <= S_DATA_TX;
        end
        S_DATA_TX: begin
          if (!tx_busy_i) begin
            addr_q  <= addr_q + 1'b1;
            len_q   <= len_q - 1'b1;
            state_q <= S_DATA;
          end
        end
        default: begin
          if (!tx_busy_i) state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_HDR && rx_valid_i) hdr_q <= hdr_next;
  end

  // Data byte from the UART or picked from the returned word
  always_ff @(posedge clk) begin
    if (state_q == S_DATA_RX && rx_valid_i) data_q <= rx_byte_i;
    else if (state_q == S_DATA_RD && mem_rvalid_i) data_q <= mem_rdata_i[8*addr_q[1:0] +: 8];
  end

  always_comb begin
    tx_send_o = !tx_busy_i && (state_q == S_ACK || state_q == S_DATA_TX || state_q == S_EOT);
    case (state_q)
      S_ACK:   tx_byte_o = BYTE_ACK;
      S_EOT:   tx_byte_o = BYTE_EOT;
      default: tx_byte_o = data_q;
    endcase
  end

  assign mem_req_valid_o = (state_q == S_DATA_REQ);
  assign mem_req_o.addr  = addr_q[MEM_ADDR_W-1:2];
  assign mem_req_o.we    = is_write_q;
  assign mem_req_o.wdata = {STRB_W{data_q}};
  assign mem_req_o.strb  = is_write_q ? (STRB_W'(1) << addr_q[1:0]) : '0;

endmodule
